//--- project.f
k005849_pkg.sv
clock_divider.sv
video_timing.sv
cpu_registers.sv
interrupt_control.sv
k005849_top.sv
tb_clock_gen.sv
k005849_checker.sv
tb_k005849.sv

//--- Bender.yml
package:
  name: k005849

sources:
  - files:
      - k005849_pkg.sv
      - clock_divider.sv
      - video_timing.sv
      - cpu_registers.sv
      - interrupt_control.sv
      - k005849_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - k005849_checker.sv
      - tb_k005849.sv

//--- tb_k005849.sv
module tb_k005849
	import k005849_pkg::*;
();

	// Length of one frame in master clock cycles
	localparam int FRAME_CYCLES = (int'(V_LAST) + 1) * (int'(H_LAST) + 1) * 8;
	// Length of the bus phase with some margin
	localparam int BUS_PHASE_CYCLES = 64 * 16;

	logic CK49, RES, READ, XCS, BUSE;
	cpu_addr_t A;
	cpu_data_t DBi, DBo;
	logic [3:0] HCTR, VCTR;
	logic NCK2, X1S, H2, ER, QR, EQ, HBLK, VBLK, HSYC, VSYC, SYNC;
	logic IRQ, NMI, FIRQ, IOCS;

	// Stimulus generator state
	logic [31:0] lfsr;
	// Reference model of the chip, counted from reset release
	int edges, h_m, v_m, phase_steps, frames_done;
	int irq_falls, firq_falls, nmi_lines, last_nmi_line;
	logic frame_odd_m, hblank_armed, vblank_armed, new_frame;
	logic er_m, qr_m, irq_m, nmi_m, firq_m;
	cpu_data_t regs_m [NUM_READABLE_REGS];
	logic [2:0] mask_m;

	tb_clock_gen clock_gen_i (.CK49(CK49), .RES(RES));

	k005849_top k005849_top_i (.*);

	// ==============================
	// Helpers
	// ==============================

	// Right shifting Galois LFSR
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
	endfunction

	// One LFSR step per bit handed out
	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped after a failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			fail_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Applies one rising edge with the inputs that were stable across it
	task automatic model_step();
		logic cen6;
		logic cen3;
		logic vbs;
		logic nmi_cond;
		logic firq_cond;
		logic [2:0] mask_old;
		cen6 = (edges % 8) == 0;
		cen3 = (edges % 16) == 0;
		mask_old = mask_m;
		// All conditions come from the state before this edge
		vbs = (v_m == VBLANK_START + 1) && (h_m == 0);
		nmi_cond = (v_m % NMI_PERIOD) == NMI_PERIOD - 1;
		firq_cond = !frame_odd_m && (v_m == FIRQ_LINE);
		if (cen6) begin
			if (!mask_old[IRQ_MASK_BIT]) begin
				irq_m = 1'b1;
			end else if (vbs) begin
				if (irq_m) irq_falls++;
				irq_m = 1'b0;
			end
		end
		if (cen3) begin
			if (!mask_old[NMI_MASK_BIT]) begin
				nmi_m = 1'b1;
			end else if (nmi_cond) begin
				// Count each line with a new NMI only once
				if (nmi_m && v_m != last_nmi_line) begin
					nmi_lines++;
					last_nmi_line = v_m;
				end
				nmi_m = 1'b0;
			end
			if (!mask_old[FIRQ_MASK_BIT]) begin
				firq_m = 1'b1;
			end else if (firq_cond) begin
				if (firq_m) firq_falls++;
				firq_m = 1'b0;
			end
			// Register writes land on the CPU clock enable
			if (!XCS && READ && A[13:12] == REG_PAGE && A[7:3] == REG_BASE) begin
				if (!A[2]) regs_m[A[1:0]] = DBi;
				else if (A[1:0] == 2'b00) mask_m = DBi[2:0];
			end
		end
		if (cen6) begin
			if (h_m == H_LAST) begin
				h_m = 0;
				// Frame parity flips as the last visible line ends
				if (v_m == VBLANK_START) frame_odd_m = !frame_odd_m;
				v_m = (v_m == V_LAST) ? 0 : v_m + 1;
				if (v_m == 0) new_frame = 1'b1;
			end else begin
				h_m++;
			end
			// Blanking flags come out of reset low until their first start
			if (h_m == HBLANK_START + 1) hblank_armed = 1'b1;
			if (v_m == VBLANK_START + 1) vblank_armed = 1'b1;
			// E low, Q high, E high, Q low
			case (phase_steps % 4)
				0: er_m = 1'b0;
				1: qr_m = 1'b1;
				2: er_m = 1'b1;
				default: qr_m = 1'b0;
			endcase
			phase_steps++;
		end
		edges++;
	endtask

	task automatic check_outputs();
		int shift;
		int hs_lo;
		int hs_hi;
		int vs_lo;
		int vs_hi;
		int addr;
		logic hs_exp;
		logic vs_exp;
		cpu_data_t dbo_exp;
		// Centering moves the horizontal window later, or earlier with bit 3 set
		if (HCTR[3]) begin
			shift = 7 - int'(HCTR[2:0]);
			hs_lo = int'(HSYNC_EARLY_LO) - shift;
			hs_hi = int'(HSYNC_EARLY_HI) - shift;
		end else begin
			hs_lo = int'(HSYNC_BASE_LO) + int'(HCTR[2:0]);
			hs_hi = int'(HSYNC_BASE_HI) + int'(HCTR[2:0]);
		end
		vs_lo = int'(VSYNC_LO) - int'(VCTR);
		vs_hi = int'(VSYNC_HI) - int'(VCTR);
		hs_exp = !(h_m >= hs_lo && h_m <= hs_hi);
		vs_exp = !(v_m >= vs_lo && v_m <= vs_hi);
		addr = int'(A);
		// Only the four exact register addresses read back
		if (!BUSE && !XCS && !READ && addr >= REG_READ_BASE
				&& addr < REG_READ_BASE + NUM_READABLE_REGS) begin
			dbo_exp = regs_m[addr - REG_READ_BASE];
		end else begin
			dbo_exp = BUS_IDLE;
		end
		check_value("X1S", h_m[0], X1S);
		check_value("H2", h_m[1], H2);
		check_value("HBLK", hblank_armed && (h_m > HBLANK_START || h_m <= HBLANK_END), HBLK);
		check_value("VBLK", vblank_armed && (v_m > VBLANK_START || v_m <= VBLANK_END), VBLK);
		check_value("HSYC", hs_exp, HSYC);
		check_value("VSYC", vs_exp, VSYC);
		check_value("SYNC", hs_exp ^ vs_exp, SYNC);
		check_value("NCK2", edges[2], NCK2);
		check_value("ER", er_m, ER);
		check_value("QR", qr_m, QR);
		check_value("EQ", er_m & qr_m, EQ);
		check_value("IRQ", irq_m, IRQ);
		check_value("NMI", nmi_m, NMI);
		check_value("FIRQ", firq_m, FIRQ);
		check_value("IOCS", !(!XCS && A[13:12] == IO_PAGE), IOCS);
		check_value("DBo", dbo_exp, DBo);
	endtask

	// Each master cycle ends with a compare at the falling edge
	task automatic tick();
		logic [31:0] r;
		@(negedge CK49);
		model_step();
		check_outputs();
		// New centering values at every frame start
		if (new_frame) begin
			draw_bits(8, r);
			HCTR = r[7:4];
			VCTR = r[3:0];
			frames_done++;
			new_frame = 1'b0;
		end
	endtask

	// A bus cycle is held for 16 master cycles, so it spans one CPU enable
	task automatic bus_cycle(input logic xcs, input logic rd, input logic oe_n,
			input cpu_addr_t addr, input cpu_data_t data);
		XCS = xcs;
		READ = rd;
		BUSE = oe_n;
		A = addr;
		DBi = data;
		repeat (16) tick();
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [31:0] r;
		logic [2:0] ack;
		READ = 1'b0;
		XCS = 1'b1;
		BUSE = 1'b1;
		A = '0;
		DBi = '0;
		HCTR = '0;
		VCTR = '0;
		lfsr = 32'd74361;
		{edges, h_m, v_m, phase_steps, frames_done} = '0;
		{irq_falls, firq_falls, nmi_lines} = '0;
		last_nmi_line = -1;
		{frame_odd_m, hblank_armed, vblank_armed, new_frame, er_m, qr_m} = '0;
		{irq_m, nmi_m, firq_m} = 3'b111;
		mask_m = '0;
		for (int i = 0; i < NUM_READABLE_REGS; i++) regs_m[i] = '0;
		@(posedge RES);
		check_value("IRQ", 1, IRQ);
		check_value("NMI", 1, NMI);
		check_value("FIRQ", 1, FIRQ);
		check_value("ER", 0, ER);
		check_value("QR", 0, QR);
		check_value("HBLK", 0, HBLK);
		check_value("VBLK", 0, VBLK);
		// Random bytes into registers 0 to 3, then read back
		for (int i = 0; i < NUM_READABLE_REGS; i++) begin
			draw_bits(8, r);
			bus_cycle(1'b0, 1'b1, 1'b1, REG_READ_BASE + cpu_addr_t'(i), r[7:0]);
		end
		for (int i = 0; i < NUM_READABLE_REGS; i++) begin
			draw_bits(8, r);
			bus_cycle(1'b0, 1'b0, 1'b0, REG_READ_BASE + cpu_addr_t'(i), r[7:0]);
		end
		// Mirrors above the window, then the same registers with BUSE high
		for (int i = 0; i < 4; i++) begin
			bus_cycle(1'b0, 1'b0, 1'b0, REG_READ_BASE + cpu_addr_t'(4 + i), 8'h00);
			bus_cycle(1'b0, 1'b0, 1'b1, REG_READ_BASE + cpu_addr_t'(i), 8'h00);
		end
		// Random read cycles over all pages exercise IOCS and idle reads
		for (int i = 0; i < 32; i++) begin
			draw_bits(16, r);
			bus_cycle(r[15], 1'b0, r[14], r[13:0], 8'h00);
		end
		draw_bits(8, r);
		HCTR = r[7:4];
		VCTR = r[3:0];
		// Two frames run with the masks set and each interrupt acknowledged like a CPU
		while (frames_done < 2) begin
			draw_bits(16, r);
			ack = 3'b111;
			ack[IRQ_MASK_BIT] = irq_m;
			ack[NMI_MASK_BIT] = nmi_m;
			ack[FIRQ_MASK_BIT] = firq_m;
			if (ack != mask_m) begin
				bus_cycle(1'b0, 1'b1, 1'b1, REG_READ_BASE + 14'd4, {r[7:3], ack});
			end else begin
				bus_cycle(1'b1, r[15], r[14], r[13:0], r[7:0]);
			end
		end
		// Clearing every mask leaves all three lines high
		bus_cycle(1'b0, 1'b1, 1'b1, REG_READ_BASE + 14'd4, 8'h00);
		bus_cycle(1'b1, 1'b0, 1'b1, '0, 8'h00);
		check_value("IRQ", 1, IRQ);
		check_value("NMI", 1, NMI);
		check_value("FIRQ", 1, FIRQ);
		if (irq_falls >= 2 && firq_falls >= 1 && nmi_lines >= 16) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			fail_run("Fewer interrupts were raised over two frames than the timing calls for");
		end
	end

	// The watchdog allows three frames plus the bus phase
	initial begin
		#(20 * (3 * FRAME_CYCLES + BUS_PHASE_CYCLES));
		fail_run("Timeout: the run did not finish before the watchdog expired");
	end

endmodule

//--- k005849_checker.sv
module k005849_checker (
	input logic CK49,
	input logic RES,
	input logic cen_3m,
	input logic nmi_mask,
	input logic irq_mask,
	input logic firq_mask,
	input logic er,
	input logic qr,
	input logic eq,
	input logic hsyc,
	input logic vsyc,
	input logic sync,
	input logic irq,
	input logic nmi,
	input logic firq
);

	// EQ is the AND of the two 6809 clocks
	eq_is_and: assert property (@(posedge CK49) disable iff (!RES) eq == (er & qr))
		else $error("EQ is not the AND of ER and QR");

	// Composite sync is the XOR of both syncs
	sync_is_xor: assert property (@(posedge CK49) disable iff (!RES) sync == (hsyc ^ vsyc))
		else $error("SYNC is not HSYC XOR VSYC");

	// A mask that is already clear at a CPU enable forces its line high right after
	irq_released: assert property (@(posedge CK49) disable iff (!RES)
		(cen_3m && !irq_mask) |=> irq) else $error("IRQ low with its mask clear");
	nmi_released: assert property (@(posedge CK49) disable iff (!RES)
		(cen_3m && !nmi_mask) |=> nmi) else $error("NMI low with its mask clear");
	firq_released: assert property (@(posedge CK49) disable iff (!RES)
		(cen_3m && !firq_mask) |=> firq) else $error("FIRQ low with its mask clear");

endmodule

bind k005849_top k005849_checker k005849_checker_i (
	.CK49(CK49), .RES(RES), .cen_3m(cen_3m),
	.nmi_mask(nmi_mask), .irq_mask(irq_mask), .firq_mask(firq_mask),
	.er(ER), .qr(QR), .eq(EQ), .hsyc(HSYC), .vsyc(VSYC), .sync(SYNC),
	.irq(IRQ), .nmi(NMI), .firq(FIRQ)
);

//--- tb_clock_gen.sv
module tb_clock_gen (
	output logic CK49,
	output logic RES
);

	// Master clock with a period of 20 time units
	initial begin
		CK49 = 1'b0;
		forever #10 CK49 = ~CK49;
	end

	// Reset stays low for four rising edges and is released on a falling edge
	initial begin
		RES = 1'b0;
		repeat (4) @(posedge CK49);
		@(negedge CK49);
		RES = 1'b1;
	end

endmodule

//--- k005849_top.sv
module k005849_top
	import k005849_pkg::*;
(
	input  logic       CK49,
	input  logic       RES,
	input  logic       READ,
	input  cpu_addr_t  A,
	input  cpu_data_t  DBi,
	output cpu_data_t  DBo,
	input  logic       XCS,
	input  logic       BUSE,
	input  logic [3:0] HCTR,
	input  logic [3:0] VCTR,
	output logic       NCK2,
	output logic       X1S,
	output logic       H2,
	output logic       ER,
	output logic       QR,
	output logic       EQ,
	output logic       HBLK,
	output logic       VBLK,
	output logic       HSYC,
	output logic       VSYC,
	output logic       SYNC,
	output logic       IRQ,
	output logic       NMI,
	output logic       FIRQ,
	output logic       IOCS
);

	// Clock enables shared by the blocks
	logic cen_6m;
	logic cen_3m;
	// Video counters and frame events
	hcount_t h_count;
	vcount_t v_count;
	logic frame_odd;
	logic vblank_start;
	// Mask bits from register 4
	logic nmi_mask;
	logic irq_mask;
	logic firq_mask;

	clock_divider clock_divider_i (
		.CK49(CK49), .RES(RES), .cen_6m(cen_6m), .cen_3m(cen_3m),
		.nck2(NCK2), .er(ER), .qr(QR), .eq(EQ)
	);

	video_timing video_timing_i (
		.CK49(CK49), .RES(RES), .cen_6m(cen_6m), .hctr(HCTR), .vctr(VCTR),
		.h_count(h_count), .v_count(v_count), .hblank(HBLK), .vblank(VBLK),
		.hsync(HSYC), .vsync(VSYC), .sync(SYNC),
		.frame_odd(frame_odd), .vblank_start(vblank_start)
	);

	cpu_registers cpu_registers_i (
		.CK49(CK49), .RES(RES), .cen_3m(cen_3m), .read(READ), .xcs(XCS), .buse(BUSE),
		.a(A), .dbi(DBi), .dbo(DBo), .iocs(IOCS),
		.nmi_mask(nmi_mask), .irq_mask(irq_mask), .firq_mask(firq_mask)
	);

	interrupt_control interrupt_control_i (
		.CK49(CK49), .RES(RES), .cen_6m(cen_6m), .cen_3m(cen_3m),
		.v_count(v_count), .frame_odd(frame_odd), .vblank_start(vblank_start),
		.nmi_mask(nmi_mask), .irq_mask(irq_mask), .firq_mask(firq_mask),
		.irq(IRQ), .nmi(NMI), .firq(FIRQ)
	);

	// Dot clock divisions come straight from the low dot counter bits
	assign X1S = h_count[0];
	assign H2 = h_count[1];

endmodule

//--- interrupt_control.sv
module interrupt_control
	import k005849_pkg::*;
(
	input  logic    CK49,
	input  logic    RES,
	input  logic    cen_6m,
	input  logic    cen_3m,
	input  vcount_t v_count,
	input  logic    frame_odd,
	input  logic    vblank_start,
	input  logic    nmi_mask,
	input  logic    irq_mask,
	input  logic    firq_mask,
	output logic    irq,
	output logic    nmi,
	output logic    firq
);

	// NMI fires on the last line of every 32 line group
	logic nmi_line;
	// FIRQ fires on the first blanking line of even frames only
	logic firq_line;

	assign nmi_line = ((v_count % NMI_PERIOD) == (NMI_PERIOD - 1));
	assign firq_line = ~frame_odd && (v_count == FIRQ_LINE);

	// All three lines are active low and latch until the CPU drops the mask
	// Clearing a mask releases the line on that channel's next enable

	// Vblank IRQ runs on the pixel clock so it catches the one dot pulse
	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			irq <= 1'b1;
		end else if (cen_6m) begin
			if (!irq_mask) begin
				irq <= 1'b1;
			end else if (vblank_start) begin
				irq <= 1'b0;
			end
		end
	end

	// NMI and FIRQ sample whole line conditions on the CPU clock enable
	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			nmi <= 1'b1;
			firq <= 1'b1;
		end else if (cen_3m) begin
			if (!nmi_mask) begin
				nmi <= 1'b1;
			end else if (nmi_line) begin
				nmi <= 1'b0;
			end
			if (!firq_mask) begin
				firq <= 1'b1;
			end else if (firq_line) begin
				firq <= 1'b0;
			end
		end
	end

endmodule

//--- cpu_registers.sv
module cpu_registers
	import k005849_pkg::*;
(
	input  logic      CK49,
	input  logic      RES,
	input  logic      cen_3m,
	input  logic      read,
	input  logic      xcs,
	input  logic      buse,
	input  cpu_addr_t a,
	input  cpu_data_t dbi,
	output cpu_data_t dbo,
	output logic      iocs,
	output logic      nmi_mask,
	output logic      irq_mask,
	output logic      firq_mask
);

	// Registers 0 to 3 are kept whole and can be read back
	cpu_data_t reg_file [NUM_READABLE_REGS];
	// Register 4 keeps its three interrupt mask bits
	logic [2:0] mask_bits;
	// Chip is selected and the address falls in the register block
	logic reg_sel;
	// Address lies in the readable window 2040 to 2043
	logic read_hit;
	// Offset of the addressed register inside the readable window
	logic [1:0] read_idx;

	// ==============================
	// Address decode
	// ==============================

	assign reg_sel = ~xcs && (a[13:12] == REG_PAGE) && (a[7:3] == REG_BASE);

	// Only the exact addresses read back and mirrors of the block return idle
	assign read_hit = (a >= REG_READ_BASE) && (a < REG_READ_BASE + NUM_READABLE_REGS);
	assign read_idx = a[1:0];

	// The external I/O decoder is enabled for the whole I/O page (active low)
	assign iocs = ~(~xcs && (a[13:12] == IO_PAGE));

	// ==============================
	// Register writes
	// ==============================

	// READ high marks a write cycle, sampled on the CPU clock enable
	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			for (int i = 0; i < NUM_READABLE_REGS; i++) begin
				reg_file[i] <= '0;
			end
			mask_bits <= 3'd0;
		end else if (cen_3m && reg_sel && read) begin
			case (a[2:0])
				3'd0, 3'd1, 3'd2, 3'd3: reg_file[a[1:0]] <= dbi;
				3'd4: mask_bits <= dbi[2:0];
				default: begin
				end
			endcase
		end
	end

	assign nmi_mask = mask_bits[NMI_MASK_BIT];
	assign irq_mask = mask_bits[IRQ_MASK_BIT];
	assign firq_mask = mask_bits[FIRQ_MASK_BIT];

	// Readback is combinational while BUSE is low
	// Anything not decoded leaves the bus floating high
	always_comb begin
		if (!buse && reg_sel && !read && read_hit) begin
			dbo = reg_file[read_idx];
		end else begin
			dbo = BUS_IDLE;
		end
	end

endmodule

//--- video_timing.sv
module video_timing
	import k005849_pkg::*;
(
	input  logic       CK49,
	input  logic       RES,
	input  logic       cen_6m,
	input  logic [3:0] hctr,
	input  logic [3:0] vctr,
	output hcount_t    h_count,
	output vcount_t    v_count,
	output logic       hblank,
	output logic       vblank,
	output logic       hsync,
	output logic       vsync,
	output logic       sync,
	output logic       frame_odd,
	output logic       vblank_start
);

	// Sync window edges after centering
	hcount_t hs_lo;
	hcount_t hs_hi;
	vcount_t vs_lo;
	vcount_t vs_hi;
	// Leftward shift used when HCTR bit 3 is set
	logic [2:0] early_shift;

	// ==============================
	// Counters and blanking
	// ==============================

	// Everything here advances on the pixel clock enable only
	// The line counter steps when the dot counter wraps
	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			h_count <= '0;
			v_count <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			frame_odd <= 1'b0;
			vblank_start <= 1'b0;
		end else if (cen_6m) begin
			// The vblank start pulse only lasts for dot 0 of line 240
			if (h_count == '0) begin
				vblank_start <= 1'b0;
			end
			// Blanking flags are registered, so they change one dot after the compare
			if (h_count == HBLANK_END) begin
				hblank <= 1'b0;
			end
			if (h_count == HBLANK_START) begin
				hblank <= 1'b1;
			end
			if (h_count == H_LAST) begin
				h_count <= '0;
				if (v_count == V_LAST) begin
					v_count <= '0;
				end else begin
					v_count <= v_count + 9'd1;
				end
				if (v_count == VBLANK_END) begin
					vblank <= 1'b0;
				end
				// End of the last visible line opens vertical blanking
				if (v_count == VBLANK_START) begin
					vblank <= 1'b1;
					vblank_start <= 1'b1;
					frame_odd <= ~frame_odd;
				end
			end else begin
				h_count <= h_count + 9'd1;
			end
		end
	end

	// ==============================
	// Sync with screen centering
	// ==============================

	// With HCTR bit 3 set the window moves left by 7 minus HCTR[2:0]
	assign early_shift = 3'd7 - hctr[2:0];

	always_comb begin
		if (hctr[3]) begin
			hs_lo = HSYNC_EARLY_LO - {6'd0, early_shift};
			hs_hi = HSYNC_EARLY_HI - {6'd0, early_shift};
		end else begin
			hs_lo = HSYNC_BASE_LO + {6'd0, hctr[2:0]};
			hs_hi = HSYNC_BASE_HI + {6'd0, hctr[2:0]};
		end
	end

	// Vertical centering only ever moves the pulse upward
	assign vs_lo = VSYNC_LO - {5'd0, vctr};
	assign vs_hi = VSYNC_HI - {5'd0, vctr};

	// Both syncs are active low and decoded straight from the counters
	assign hsync = ~((h_count >= hs_lo) && (h_count <= hs_hi));
	assign vsync = ~((v_count >= vs_lo) && (v_count <= vs_hi));

	// Composite sync for monitors that take a single sync line
	assign sync = hsync ^ vsync;

endmodule

//--- clock_divider.sv
module clock_divider
	import k005849_pkg::*;
(
	input  logic CK49,
	input  logic RES,
	output logic cen_6m,
	output logic cen_3m,
	output logic nck2,
	output logic er,
	output logic qr,
	output logic eq
);

	// Free running divider of the 49.152 MHz master clock
	logic [3:0] div;
	// Current step of the E/Q generator
	clk_phase_t phase;

	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			div <= 4'd0;
		end else begin
			div <= div + 4'd1;
		end
	end

	// Pixel clock enable every 8 master cycles, CPU enable every 16
	assign cen_6m = (div[2:0] == 3'd0);
	assign cen_3m = (div == 4'd0);

	// 6.144 MHz square wave for the board
	assign nck2 = div[2];

	// The 6809E wants E and Q a quarter period apart
	// Each pixel clock moves one edge, so a full E cycle takes four steps
	always_ff @(posedge CK49 or negedge RES) begin
		if (!RES) begin
			phase <= PH_E_FALL;
			er <= 1'b0;
			qr <= 1'b0;
		end else if (cen_6m) begin
			case (phase)
				PH_E_FALL: begin
					er <= 1'b0;
					phase <= PH_Q_RISE;
				end
				PH_Q_RISE: begin
					qr <= 1'b1;
					phase <= PH_E_RISE;
				end
				PH_E_RISE: begin
					er <= 1'b1;
					phase <= PH_Q_FALL;
				end
				default: begin
					qr <= 1'b0;
					phase <= PH_E_FALL;
				end
			endcase
		end
	end

	// EQ is the AND of both CPU clocks
	assign eq = er & qr;

endmodule

//--- k005849_pkg.sv
package k005849_pkg;

	// ==============================
	// Widths that carry a meaning
	// ==============================

	// Horizontal dot counter, 384 dots per line
	typedef logic [8:0] hcount_t;
	// Vertical line counter, 264 lines per frame
	typedef logic [8:0] vcount_t;
	// CPU address bus as seen by the chip
	typedef logic [13:0] cpu_addr_t;
	// One byte on the CPU data bus
	typedef logic [7:0] cpu_data_t;

	// Steps of the 6809 E/Q generator, one step per pixel clock
	typedef enum logic [1:0] {
		PH_E_FALL = 2'd0,
		PH_Q_RISE = 2'd1,
		PH_E_RISE = 2'd2,
		PH_Q_FALL = 2'd3
	} clk_phase_t;

	// ==============================
	// Video timing
	// ==============================

	localparam hcount_t H_LAST = 9'd383;
	localparam hcount_t HBLANK_END = 9'd1;
	localparam hcount_t HBLANK_START = 9'd257;
	localparam vcount_t V_LAST = 9'd263;
	localparam vcount_t VBLANK_END = 9'd15;
	localparam vcount_t VBLANK_START = 9'd239;
	localparam vcount_t FIRQ_LINE = 9'd240;
	localparam int NMI_PERIOD = 32;

	// Normal HSYNC window, moved later by the centering value
	localparam hcount_t HSYNC_BASE_LO = 9'd293;
	localparam hcount_t HSYNC_BASE_HI = 9'd324;
	// HSYNC window used when the picture is pulled to the left
	localparam hcount_t HSYNC_EARLY_LO = 9'd285;
	localparam hcount_t HSYNC_EARLY_HI = 9'd316;
	// VSYNC window before the vertical centering offset
	localparam vcount_t VSYNC_LO = 9'd254;
	localparam vcount_t VSYNC_HI = 9'd261;

	// ==============================
	// CPU register map
	// ==============================

	// A[13:12] page codes
	localparam logic [1:0] REG_PAGE = 2'b10;
	localparam logic [1:0] IO_PAGE = 2'b11;
	// A[7:3] of the control register block inside the register page
	localparam logic [4:0] REG_BASE = 5'b01000;
	localparam cpu_addr_t REG_READ_BASE = 14'h2040;
	localparam int NUM_READABLE_REGS = 4;

	// Interrupt mask positions in register 4
	localparam int NMI_MASK_BIT = 0;
	localparam int IRQ_MASK_BIT = 1;
	localparam int FIRQ_MASK_BIT = 2;

	localparam cpu_data_t BUS_IDLE = 8'hFF;

endpackage
